// File: compile.f
design/bridge_axi_pkg.sv
design/bridge_ahb_pkg.sv
design/axi_cmd_decode.sv
design/ahb_sequencer.sv
design/axi_resp_gen.sv
design/axi_ahb_bridge.sv
sim/ahb_slave_model.sv
sim/bridge_tb.sv

// File: design/ahb_sequencer.sv
// AHB-Lite master sequencer
// Runs one command as a single transfer or a string of byte transfers, then reports it

`timescale 1ns/1ps

module ahb_sequencer (
   input  logic                                   bus_clk,
   input  logic                                   reset,
   input  bridge_axi_pkg::bridge_cmd_t            cmd,
   input  logic                                   cmd_valid,
   output logic                                   cmd_ready,
   output bridge_ahb_pkg::ahb_addr_phase_t        ahb_addr,
   output logic [bridge_axi_pkg::data_w-1:0]      hwdata,
   input  logic [bridge_axi_pkg::data_w-1:0]      hrdata,
   input  logic                                   hready,
   input  logic                                   hresp,
   output bridge_axi_pkg::bridge_rsp_t            rsp,
   output logic                                   rsp_valid,
   input  logic                                   rsp_ready
);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_data,
      st_done
   } seq_state_t;

   seq_state_t                  state;
   bridge_axi_pkg::bridge_cmd_t cmd_q;
   logic [2:0]                  ptr;          // Current byte lane
   logic [2:0]                  addr_ptr;
   logic [3:0]                  first_lane;   // {found, lane}
   logic [3:0]                  next_lane;
   logic                        more;
   logic                        issue_next;
   logic                        take;
   logic                        err;
   logic [bridge_axi_pkg::data_w-1:0] rdata_q;

   // Lowest set strobe lane at or above start
   function automatic logic [3:0] find_lane(input logic [7:0] strb, input logic [3:0] start);
      logic [3:0] res;
      res = 4'd0;
      for (int i = 7; i >= 0; i--) begin
         if (strb[i] && (4'(i) >= start)) res = {1'b1, 3'(i)};
      end
      return res;
   endfunction

   assign take       = cmd_valid & cmd_ready;
   assign first_lane = find_lane(cmd.strb, 4'd0);
   assign next_lane  = find_lane(cmd_q.strb, {1'b0, ptr} + 4'd1);
   assign more       = cmd_q.write & cmd_q.split & next_lane[3];
   // Next byte overlaps the current data phase, dropped on an error
   assign issue_next = (state == st_data) & more & ~hresp;
   assign addr_ptr   = (state == st_data) ? next_lane[2:0] : ptr;

   // ****************************************
   // AHB address and data phase outputs
   // ****************************************
   always_comb begin
      ahb_addr.haddr  = {cmd_q.addr[bridge_axi_pkg::addr_w-1:3], addr_ptr};
      ahb_addr.hsize  = cmd_q.size;
      ahb_addr.hwrite = cmd_q.write;
      ahb_addr.hprot  = {bridge_ahb_pkg::hprot_fixed, cmd_q.hprot_d};
      if ((state == st_addr) || issue_next) begin
         ahb_addr.htrans = bridge_ahb_pkg::htrans_nonseq;
      end else begin
         ahb_addr.htrans = bridge_ahb_pkg::htrans_idle;
      end
   end

   assign hwdata    = cmd_q.data;   // Stable through every data phase of the command
   assign cmd_ready = (state == st_idle);
   assign rsp_valid = (state == st_done);

   always_comb begin
      rsp.write = cmd_q.write;
      rsp.tag   = cmd_q.tag;
      rsp.error = err;
      rsp.rdata = rdata_q;
   end

   // ****************************************
   // State machine
   // ****************************************
   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state <= st_idle;
         err   <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (take) begin
                  err <= 1'b0;
                  // A split write with no strobe bits has nothing to send
                  if (cmd.write & cmd.split & ~first_lane[3]) state <= st_done;
                  else state <= st_addr;
               end
            end
            st_addr: begin
               if (hready) state <= st_data;   // Address phase taken
            end
            st_data: begin
               if (hready) begin
                  if (hresp) begin
                     err   <= 1'b1;            // Second error cycle, stop here
                     state <= st_done;
                  end else if (!more) begin
                     state <= st_done;
                  end
               end
            end
            st_done: begin
               if (rsp_ready) state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Command, lane pointer and read data
   always_ff @(posedge bus_clk) begin
      if (take) begin
         cmd_q <= cmd;
         ptr   <= cmd.split ? first_lane[2:0] : cmd.addr[2:0];
      end
      if ((state == st_data) && hready && !hresp && more) begin
         ptr <= next_lane[2:0];                // Next byte address was taken
      end
      if ((state == st_data) && hready && !cmd_q.write) begin
         rdata_q <= hrdata;
      end
   end

endmodule

// File: design/axi_ahb_bridge.sv
// AXI4 slave to AHB-Lite master bridge, 64 bits on both sides
// Decode feeds the AHB sequencer, whose completions go to the response generator

`timescale 1ns/1ps

module axi_ahb_bridge (
   input  logic                               bus_clk,
   input  logic                               reset,
   // AXI write channels
   input  bridge_axi_pkg::axi_addr_t          aw,
   input  logic                               aw_valid,
   output logic                               aw_ready,
   input  bridge_axi_pkg::axi_wdata_t         w,
   input  logic                               w_valid,
   output logic                               w_ready,
   output bridge_axi_pkg::axi_b_t             b,
   output logic                               b_valid,
   input  logic                               b_ready,
   // AXI read channels
   input  bridge_axi_pkg::axi_addr_t          ar,
   input  logic                               ar_valid,
   output logic                               ar_ready,
   output bridge_axi_pkg::axi_r_t             r,
   output logic                               r_valid,
   input  logic                               r_ready,
   // AHB-Lite master
   output bridge_ahb_pkg::ahb_addr_phase_t    ahb_addr,
   output logic [bridge_axi_pkg::data_w-1:0]  hwdata,
   input  logic [bridge_axi_pkg::data_w-1:0]  hrdata,
   input  logic                               hready,
   input  logic                               hresp
);

   bridge_axi_pkg::bridge_cmd_t cmd;
   logic                        cmd_valid;
   logic                        cmd_ready;
   bridge_axi_pkg::bridge_rsp_t rsp;
   logic                        rsp_valid;
   logic                        rsp_ready;

   axi_cmd_decode u_decode (
      .bus_clk, .reset,
      .aw, .aw_valid, .aw_ready,
      .w, .w_valid, .w_ready,
      .ar, .ar_valid, .ar_ready,
      .cmd, .cmd_valid, .cmd_ready
   );

   ahb_sequencer u_execute (
      .bus_clk, .reset,
      .cmd, .cmd_valid, .cmd_ready,
      .ahb_addr, .hwdata, .hrdata, .hready, .hresp,
      .rsp, .rsp_valid, .rsp_ready
   );

   axi_resp_gen u_result (
      .bus_clk, .reset,
      .rsp, .rsp_valid, .rsp_ready,
      .b, .b_valid, .r_valid, .b_ready, .r_ready, .r
   );

endmodule

// File: design/axi_cmd_decode.sv
// AXI request decode
// Buffers AW and W, gives a complete write priority over AR, registers one command

`timescale 1ns/1ps

module axi_cmd_decode (
   input  logic                         bus_clk,
   input  logic                         reset,
   input  bridge_axi_pkg::axi_addr_t    aw,
   input  logic                         aw_valid,
   output logic                         aw_ready,
   input  bridge_axi_pkg::axi_wdata_t   w,
   input  logic                         w_valid,
   output logic                         w_ready,
   input  bridge_axi_pkg::axi_addr_t    ar,
   input  logic                         ar_valid,
   output logic                         ar_ready,
   output bridge_axi_pkg::bridge_cmd_t  cmd,
   output logic                         cmd_valid,
   input  logic                         cmd_ready
);

   bridge_axi_pkg::axi_addr_t   aw_q;
   bridge_axi_pkg::axi_wdata_t  w_q;
   bridge_axi_pkg::bridge_cmd_t wr_cmd;
   bridge_axi_pkg::bridge_cmd_t rd_cmd;
   logic       aw_full;
   logic       w_full;
   logic       run;            // Low only while in reset
   logic       wr_complete;
   logic       cmd_free;
   logic       wr_load;
   logic       rd_load;
   logic       strb_aligned;
   logic [2:0] strb_size;
   logic [2:0] strb_low;

   assign aw_ready    = run & ~aw_full;
   assign w_ready     = run & ~w_full;
   assign wr_complete = aw_full & w_full;
   assign cmd_free    = ~cmd_valid | cmd_ready;
   assign ar_ready    = run & ~wr_complete & cmd_free;   // Writes win
   assign wr_load     = wr_complete & cmd_free;
   assign rd_load     = ar_valid & ar_ready;

   // ****************************************
   // Strobe decode for 64-bit writes
   // ****************************************
   always_comb begin
      strb_aligned = 1'b1;
      strb_size    = bridge_ahb_pkg::hsize_byte;
      strb_low     = 3'd0;
      case (w_q.strb)
         8'hff:                      strb_size = bridge_ahb_pkg::hsize_dword;
         8'h0f, 8'hf0:               strb_size = bridge_ahb_pkg::hsize_word;
         8'h03, 8'h0c, 8'h30, 8'hc0: strb_size = bridge_ahb_pkg::hsize_half;
         8'h01, 8'h02, 8'h04, 8'h08,
         8'h10, 8'h20, 8'h40, 8'h80: strb_size = bridge_ahb_pkg::hsize_byte;
         default:                    strb_aligned = 1'b0;
      endcase
      // Lowest set lane is the start of any aligned group
      for (int i = 7; i >= 0; i--) begin
         if (w_q.strb[i]) strb_low = 3'(i);
      end
   end

   always_comb begin
      wr_cmd         = '0;
      wr_cmd.write   = 1'b1;
      wr_cmd.tag     = aw_q.id;
      wr_cmd.addr    = aw_q.addr;
      wr_cmd.size    = aw_q.size;
      wr_cmd.strb    = w_q.strb;
      wr_cmd.data    = w_q.data;
      wr_cmd.hprot_d = ~aw_q.prot[2];
      if (aw_q.size == bridge_ahb_pkg::hsize_dword) begin
         wr_cmd.split     = ~strb_aligned;
         wr_cmd.size      = strb_aligned ? strb_size : bridge_ahb_pkg::hsize_byte;
         wr_cmd.addr[2:0] = strb_aligned ? strb_low : 3'd0;
      end
   end

   always_comb begin
      rd_cmd         = '0;
      rd_cmd.tag     = ar.id;
      rd_cmd.addr    = ar.addr;
      rd_cmd.size    = ar.size;
      rd_cmd.hprot_d = ~ar.prot[2];
   end

   // Slot flags and command valid
   always_ff @(posedge bus_clk) begin
      if (reset) begin
         run       <= 1'b0;
         aw_full   <= 1'b0;
         w_full    <= 1'b0;
         cmd_valid <= 1'b0;
      end else begin
         run       <= 1'b1;
         aw_full   <= (aw_full & ~wr_load) | (aw_valid & aw_ready);
         w_full    <= (w_full & ~wr_load) | (w_valid & w_ready);
         cmd_valid <= wr_load | rd_load | (cmd_valid & ~cmd_ready);
      end
   end

   // Payload registers
   always_ff @(posedge bus_clk) begin
      if (aw_valid & aw_ready) aw_q <= aw;
      if (w_valid & w_ready) w_q <= w;
      if (wr_load) begin
         cmd <= wr_cmd;
      end else if (rd_load) begin
         cmd <= rd_cmd;
      end
   end

endmodule

// File: design/axi_resp_gen.sv
// AXI response generator
// Holds one completion and presents it on B or R until accepted

`timescale 1ns/1ps

module axi_resp_gen (
   input  logic                        bus_clk,
   input  logic                        reset,
   input  bridge_axi_pkg::bridge_rsp_t rsp,
   input  logic                        rsp_valid,
   output logic                        rsp_ready,
   output bridge_axi_pkg::axi_b_t      b,
   output logic                        b_valid,
   output logic                        r_valid,
   input  logic                        b_ready,
   input  logic                        r_ready,
   output bridge_axi_pkg::axi_r_t      r
);

   bridge_axi_pkg::bridge_rsp_t slot;
   logic                        slot_full;
   logic                        release_slot;
   logic [1:0]                  resp_code;

   assign rsp_ready    = ~slot_full;
   assign b_valid      = slot_full & slot.write;
   assign r_valid      = slot_full & ~slot.write;
   assign release_slot = (b_valid & b_ready) | (r_valid & r_ready);

   // Any AHB error becomes SLVERR
   assign resp_code = slot.error ? bridge_axi_pkg::resp_slverr : bridge_axi_pkg::resp_okay;

   always_comb begin
      b.id   = slot.tag;
      b.resp = resp_code;
      r.id   = slot.tag;
      r.data = slot.rdata;   // Unspecified when the read failed
      r.resp = resp_code;
   end

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         slot_full <= 1'b0;
      end else if (rsp_valid & rsp_ready) begin
         slot_full <= 1'b1;
      end else if (release_slot) begin
         slot_full <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rsp_valid & rsp_ready) slot <= rsp;
   end

endmodule

// File: design/bridge_ahb_pkg.sv
// AHB-Lite side definitions for the bridge
// Transfer and size codes plus the address phase bundle

package bridge_ahb_pkg;

   localparam int haddr_w = 32;

   // ****************************************
   // Transfer type codes
   // ****************************************
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;   // Every transfer is a single

   // ****************************************
   // Transfer size codes
   // ****************************************
   localparam logic [2:0] hsize_byte  = 3'b000;
   localparam logic [2:0] hsize_half  = 3'b001;
   localparam logic [2:0] hsize_word  = 3'b010;
   localparam logic [2:0] hsize_dword = 3'b011;

   // Upper hprot bits: privileged, not bufferable, not cacheable
   localparam logic [2:0] hprot_fixed = 3'b001;

   // Everything the master drives during one address phase
   typedef struct packed {
      logic [haddr_w-1:0] haddr;
      logic [2:0]         hsize;
      logic [1:0]         htrans;
      logic               hwrite;
      logic [3:0]         hprot;   // hprot[0] is the data/opcode bit
   } ahb_addr_phase_t;

endpackage

// File: design/bridge_axi_pkg.sv
// AXI side definitions for the AXI4 to AHB-Lite bridge
// Channel payloads plus the internal command and completion records

package bridge_axi_pkg;

   // Bus widths
   localparam int tag_w  = 4;
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;

   // Only two response codes are ever returned
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // AW and AR payload
   typedef struct packed {
      logic [tag_w-1:0]  id;
      logic [addr_w-1:0] addr;
      logic [2:0]        size;
      logic [2:0]        prot;   // prot[2] set means instruction fetch
   } axi_addr_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } axi_wdata_t;

   typedef struct packed {
      logic [tag_w-1:0] id;
      logic [1:0]       resp;
   } axi_b_t;

   // Single beat only, rlast is tied high at the port
   typedef struct packed {
      logic [tag_w-1:0]  id;
      logic [data_w-1:0] data;
      logic [1:0]        resp;
   } axi_r_t;

   // One decoded request, ready for the AHB sequencer
   typedef struct packed {
      logic              write;
      logic              split;    // Write goes out one byte lane at a time
      logic [tag_w-1:0]  tag;
      logic [addr_w-1:0] addr;     // Low bits already fixed for aligned strobes
      logic [2:0]        size;     // AHB hsize encoding
      logic [strb_w-1:0] strb;
      logic [data_w-1:0] data;
      logic              hprot_d;  // Data access when set
   } bridge_cmd_t;

   typedef struct packed {
      logic              write;
      logic [tag_w-1:0]  tag;
      logic              error;
      logic [data_w-1:0] rdata;
   } bridge_rsp_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module bridge_tb -Mdir obj_dir -f compile.f
out=$(./obj_dir/Vbridge_tb)
echo "$out"
if echo "$out" | grep -q '^>>> PASS$'; then
   exit 0
fi
exit 1

// File: sim/ahb_slave_model.sv
// AHB-Lite memory model for the bridge testbench
// Random wait states, an error window at the top of the map, a count of finished transfers

`timescale 1ns/1ps

module ahb_slave_model (
   input  logic                              bus_clk,
   input  logic                              reset,
   input  bridge_ahb_pkg::ahb_addr_phase_t   ahb_addr,
   input  logic [bridge_axi_pkg::data_w-1:0] hwdata,
   output logic [bridge_axi_pkg::data_w-1:0] hrdata,
   output logic                              hready,
   output logic                              hresp
);

   localparam logic [31:0] err_base = 32'hE000_0000;   // Everything above answers ERROR

   logic [7:0]  mem [256];
   logic        dp_active;      // A data phase is in progress
   logic        dp_write;
   logic        dp_err;
   logic [31:0] dp_addr;
   logic [2:0]  dp_size;
   logic [1:0]  wait_left;
   int          lane_lo;
   int          lane_cnt;
   int          seed = 32'h573d796d;
   int          xfer_count;     // Read by the testbench
   logic [3:0]  last_hprot;     // hprot of the latest address phase, read by the testbench

   // Error is two cycles, the first with hready low
   assign hready = ~dp_active | (wait_left == 2'd0);
   assign hresp  = dp_active & dp_err;

   // Whole doubleword around the data phase address
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         hrdata[8*i +: 8] = mem[{dp_addr[7:3], 3'(i)}];
      end
   end

   always @(posedge bus_clk) begin
      if (reset) begin
         dp_active  <= 1'b0;
         dp_err     <= 1'b0;
         wait_left  <= 2'd0;
         xfer_count <= 0;
         for (int i = 0; i < 256; i++) begin
            mem[i] <= 8'h00;
         end
      end else if (hready) begin
         if (dp_active) begin
            xfer_count <= xfer_count + 1;
            if (dp_write && !dp_err) begin
               lane_cnt = 1 << dp_size;
               lane_lo  = int'(dp_addr[2:0]) & ~(lane_cnt - 1);
               for (int i = 0; i < 8; i++) begin
                  if ((i >= lane_lo) && (i < lane_lo + lane_cnt)) begin
                     mem[{dp_addr[7:3], 3'(i)}] <= hwdata[8*i +: 8];
                  end
               end
            end
         end
         dp_active <= (ahb_addr.htrans == bridge_ahb_pkg::htrans_nonseq);
         if (ahb_addr.htrans == bridge_ahb_pkg::htrans_nonseq) begin
            dp_addr    <= ahb_addr.haddr;
            dp_write   <= ahb_addr.hwrite;
            dp_size    <= ahb_addr.hsize;
            last_hprot <= ahb_addr.hprot;
            dp_err     <= (ahb_addr.haddr >= err_base);
            if (ahb_addr.haddr >= err_base) begin
               wait_left <= 2'd1;
            end else begin
               wait_left <= 2'({$random(seed)} % 3);   // 0 to 2 wait states
            end
         end
      end else begin
         wait_left <= wait_left - 2'd1;
      end
   end

endmodule

// File: sim/bridge_tb.sv
// Testbench for the AXI4 to AHB-Lite bridge
// Replays the request trace and checks IDs, responses, read data and AHB transfer counts

`timescale 1ns/1ps

module bridge_tb;

   // One request from the trace with its expected results
   typedef struct packed {
      logic [7:0]  op;      // ASCII W or R
      logic [3:0]  id;
      logic [31:0] addr;
      logic [2:0]  size;
      logic [63:0] data;
      logic [7:0]  strb;
      logic [1:0]  resp;
      logic [63:0] rdata;
      logic [31:0] count;   // AHB transfers the request should take
   } trace_entry_t;

   logic                            bus_clk = 1'b0;
   logic                            reset;
   bridge_axi_pkg::axi_addr_t       aw;
   logic                            aw_valid;
   logic                            aw_ready;
   bridge_axi_pkg::axi_wdata_t      w;
   logic                            w_valid;
   logic                            w_ready;
   bridge_axi_pkg::axi_b_t          b;
   logic                            b_valid;
   logic                            b_ready;
   bridge_axi_pkg::axi_addr_t       ar;
   logic                            ar_valid;
   logic                            ar_ready;
   bridge_axi_pkg::axi_r_t          r;
   logic                            r_valid;
   logic                            r_ready;
   bridge_ahb_pkg::ahb_addr_phase_t ahb_addr;
   logic [63:0]                     hwdata;
   logic [63:0]                     hrdata;
   logic                            hready;
   logic                            hresp;

   trace_entry_t trace_q[$];
   int           mismatches;
   int           failures;
   int           timeouts = 0;
   int           cycles = 0;
   int           cycle_limit;
   int           seed = 32'h573d796d;

   always #2 bus_clk = ~bus_clk;

   axi_ahb_bridge DUT (
      .bus_clk, .reset,
      .aw, .aw_valid, .aw_ready,
      .w, .w_valid, .w_ready,
      .b, .b_valid, .b_ready,
      .ar, .ar_valid, .ar_ready,
      .r, .r_valid, .r_ready,
      .ahb_addr, .hwdata, .hrdata, .hready, .hresp
   );

   ahb_slave_model slave (
      .bus_clk, .reset, .ahb_addr, .hwdata, .hrdata, .hready, .hresp
   );

   // ****************************************
   // Helpers
   // ****************************************
   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
         mismatches++;
      end
   endtask

   task automatic load_trace();
      int           fd;
      int           c;
      int           n;
      string        line;
      logic [31:0]  v_id, v_addr, v_size, v_strb, v_resp, v_count;
      logic [63:0]  v_data, v_rdata;
      trace_entry_t e;
      fd = $fopen("sim/bridge_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file sim/bridge_trace.txt");
         failures++;
         return;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         if (8'(c) == "#") begin
            n = $fgets(line, fd);                        // Rest of a comment line
         end else if ((8'(c) == "W") || (8'(c) == "R")) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %d", v_id, v_addr, v_size, v_data,
                        v_strb, v_resp, v_rdata, v_count);
            if (n != 8) begin
               $display("Trace line %0d is malformed", trace_q.size() + 1);
               failures++;
            end else begin
               e.op    = 8'(c);
               e.id    = v_id[3:0];
               e.addr  = v_addr;
               e.size  = v_size[2:0];
               e.data  = v_data;
               e.strb  = v_strb[7:0];
               e.resp  = v_resp[1:0];
               e.rdata = v_rdata;
               e.count = v_count;
               trace_q.push_back(e);
            end
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   // Holds ready low for a while after valid, then takes one response
   task automatic collect_response(input logic is_write, input int delay,
                                   output logic [3:0] id, output logic [1:0] resp,
                                   output logic [63:0] rdata);
      while (!(is_write ? b_valid : r_valid)) @(posedge bus_clk);
      repeat (delay) @(posedge bus_clk);
      if (is_write) b_ready <= 1'b1;
      else r_ready <= 1'b1;
      @(posedge bus_clk);
      id    = is_write ? b.id : r.id;
      resp  = is_write ? b.resp : r.resp;
      rdata = r.data;
      b_ready <= 1'b0;
      r_ready <= 1'b0;
      @(posedge bus_clk);
      check_value("valid after accept", 64'(is_write ? b_valid : r_valid), 64'd0);   // Once only
   endtask

   task automatic run_request(input trace_entry_t e);
      int          start_count;
      int          delay;
      logic        is_write;
      logic        aw_done;
      logic        w_done;
      logic [3:0]  got_id;
      logic [1:0]  got_resp;
      logic [63:0] got_rdata;
      is_write    = (e.op == "W");
      start_count = slave.xfer_count;
      delay       = {$random(seed)} % 4;
      @(posedge bus_clk);
      if (is_write) begin
         aw       <= '{id: e.id, addr: e.addr, size: e.size, prot: 3'b000};
         aw_valid <= 1'b1;
         w        <= '{data: e.data, strb: e.strb};
         w_valid  <= 1'b1;
         aw_done  = 1'b0;
         w_done   = 1'b0;
         while (!(aw_done && w_done)) begin
            @(posedge bus_clk);
            if (aw_valid && aw_ready) begin
               aw_done  = 1'b1;
               aw_valid <= 1'b0;
            end
            if (w_valid && w_ready) begin
               w_done  = 1'b1;
               w_valid <= 1'b0;
            end
         end
      end else begin
         ar       <= '{id: e.id, addr: e.addr, size: e.size, prot: 3'b000};
         ar_valid <= 1'b1;
         @(posedge bus_clk);
         while (!ar_ready) @(posedge bus_clk);
         ar_valid <= 1'b0;
      end
      collect_response(is_write, delay, got_id, got_resp, got_rdata);
      check_value(is_write ? "b.id" : "r.id", 64'(got_id), 64'(e.id));
      check_value(is_write ? "b.resp" : "r.resp", 64'(got_resp), 64'(e.resp));
      if (!is_write && (e.resp == bridge_axi_pkg::resp_okay)) begin
         check_value("r.data", got_rdata, e.rdata);
      end
      check_value("AHB transfer count", 64'(slave.xfer_count - start_count), 64'(e.count));
      // prot[2] is low in every request, so each transfer is a data access
      if (e.count != 0) begin
         check_value("hprot", 64'(slave.last_hprot),
                     64'({bridge_ahb_pkg::hprot_fixed, 1'b1}));
      end
   endtask

   task automatic finish_run();
      $display("Requests %0d, mismatches %0d, other failures %0d",
               trace_q.size(), mismatches, failures + timeouts);
      if ((mismatches == 0) && (failures == 0) && (timeouts == 0)) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   // ****************************************
   // Watchdog
   // ****************************************
   always @(posedge bus_clk) begin
      cycles++;
      if ((cycle_limit > 0) && (cycles > cycle_limit)) begin
         $display("Run stopped after %0d cycles without finishing the trace", cycle_limit);
         timeouts++;
         finish_run();
      end
   end

   initial begin
      reset      = 1'b1;
      aw         = '0;
      aw_valid   = 1'b0;
      w          = '0;
      w_valid    = 1'b0;
      ar         = '0;
      ar_valid   = 1'b0;
      b_ready    = 1'b0;
      r_ready    = 1'b0;
      mismatches = 0;
      failures   = 0;
      cycle_limit = 0;
      load_trace();
      if (trace_q.size() == 0) begin
         $display("The trace holds no requests");
         failures++;
      end
      cycle_limit = 200 * trace_q.size();   // 200 cycles per request
      repeat (2) @(posedge bus_clk);
      reset <= 1'b0;
      foreach (trace_q[i]) begin
         run_request(trace_q[i]);
      end
      finish_run();
   end

endmodule

// File: sim/bridge_trace.txt
# op id addr size wdata strb | expected resp rdata ahb_transfers
# AXI size and strobe encoding, rdata is ignored for writes and failed reads
W 1 10000000 3 1122334455667788 ff 0 0000000000000000 1
R 2 10000000 3 0000000000000000 00 0 1122334455667788 1
W 3 10000000 3 a1a2a3a4b1b2b3b4 f0 0 0000000000000000 1
W 4 10000000 3 c1c2c3c4d1d2d3d4 0c 0 0000000000000000 1
W 5 10000000 3 e1e2e3e4f1f2f3f4 80 0 0000000000000000 1
R 6 10000000 3 0000000000000000 00 0 e1a2a3a4d1d27788 1
W 7 10000008 3 0123456789abcdef ff 0 0000000000000000 1
W 8 10000008 3 1122334455667788 5a 0 0000000000000000 4
R 9 10000008 3 0000000000000000 00 0 0122454455ab77ef 1
W a 10000010 3 ffeeddccbbaa9988 ff 0 0000000000000000 1
W b 10000010 3 0000000000000000 81 0 0000000000000000 2
R c 10000010 3 0000000000000000 00 0 00eeddccbbaa9900 1
W d 10000026 0 00ab000000000000 40 0 0000000000000000 1
W e 10000024 1 0000cdef00000000 30 0 0000000000000000 1
W f 10000020 2 0000000012345678 0f 0 0000000000000000 1
R 0 10000020 3 0000000000000000 00 0 00abcdef12345678 1
R 1 10000024 2 0000000000000000 00 0 00abcdef12345678 1
W 2 e0000000 3 1111111111111111 ff 2 0000000000000000 1
W 3 e0000008 3 2222222222222222 5a 2 0000000000000000 1
R 4 e0000010 3 0000000000000000 00 2 0000000000000000 1
W 5 e0000001 0 0000000000003300 02 2 0000000000000000 1
R 6 10000008 3 0000000000000000 00 0 0122454455ab77ef 1
W 7 10000030 3 8877665544332211 3c 0 0000000000000000 4
R 8 10000030 3 0000000000000000 00 0 0000665544330000 1
W 9 10000000 3 ffffffffffffffff 00 0 0000000000000000 0
R a 10000000 3 0000000000000000 00 0 e1a2a3a4d1d27788 1
